/* rtl/cnn_defs.svh */
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

`define CNN_CHANNELS 4   // input channels per tile
`define CNN_KSIZE    3   // kernel side
`define CNN_TSIZE    4   // image tile side
`define CNN_PIX_W    8   // pixel and weight width
`define CNN_SHIFT    6   // window sum scaling before clamp
`define CNN_ACC_W    21  // signed window sum width

`endif

/* rtl/cnn_pkg.sv */
`default_nettype none

`include "cnn_defs.svh"

package cnn_pkg;

    typedef logic signed [`CNN_PIX_W-1:0] pixel_t;
    typedef logic signed [`CNN_ACC_W-1:0] acc_t;

    typedef logic [$clog2(`CNN_CHANNELS)-1:0] chan_t;
    typedef logic [1:0] coord_t;   // row or column in kernel or tile
    typedef logic [1:0] win_t;     // bit 1 row offset, bit 0 column offset

    typedef pixel_t weight_bank_t [`CNN_CHANNELS][`CNN_KSIZE][`CNN_KSIZE];
    typedef pixel_t tile_t [`CNN_CHANNELS][`CNN_TSIZE][`CNN_TSIZE];

endpackage

`default_nettype wire

/* rtl/cnn_tile_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_tile_sequencer (
    input  wire logic            i_clk,
    input  wire logic            i_rst,
    input  wire logic            i_valid,
    output logic                 o_kernel_we,
    output logic                 o_image_we,
    output logic                 o_win_valid,
    output logic                 o_win_last,
    output cnn_pkg::chan_t       o_chan,
    output cnn_pkg::coord_t      o_row,
    output cnn_pkg::coord_t      o_col,
    output cnn_pkg::win_t        o_win
);

    typedef enum logic [1:0] {
        st_kernel,
        st_image,
        st_compute
    } state_t;

    state_t          state;
    cnn_pkg::chan_t  chan;
    cnn_pkg::coord_t row;
    cnn_pkg::coord_t col;
    cnn_pkg::win_t   win;
    logic            loading;
    logic            col_end;
    logic            row_end;
    logic            chan_end;

    assign loading  = (state == st_kernel) || (state == st_image);

    // kernel walks 3x3 bytes, image walks 4 rows of 2 column pairs
    assign col_end  = (state == st_kernel) ? (col == `CNN_KSIZE - 1)
                                           : (col == `CNN_TSIZE / 2 - 1);
    assign row_end  = (state == st_kernel) ? (row == `CNN_KSIZE - 1)
                                           : (row == `CNN_TSIZE - 1);
    assign chan_end = (chan == `CNN_CHANNELS - 1);

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            state <= st_kernel;
            chan  <= '0;
            row   <= '0;
            col   <= '0;
            win   <= '0;
        end
        else if (loading)
        begin
            if (i_valid)
            begin
                if (!col_end)
                    col <= col + 1'b1;
                else
                begin
                    col <= '0;
                    if (!row_end)
                        row <= row + 1'b1;
                    else
                    begin
                        row <= '0;
                        if (!chan_end)
                            chan <= chan + 1'b1;
                        else
                        begin
                            chan  <= '0;
                            state <= (state == st_kernel) ? st_image : st_compute;
                        end
                    end
                end
            end
        end
        else
        begin
            win <= win + 1'b1;          // wraps back to window 0
            if (win == 2'd3)
                state <= st_kernel;     // every tile reloads its kernel
        end
    end

    assign o_kernel_we = (state == st_kernel) && i_valid;
    assign o_image_we  = (state == st_image) && i_valid;
    assign o_win_valid = (state == st_compute);
    assign o_win_last  = (state == st_compute) && (win == 2'd3);
    assign o_chan      = chan;
    assign o_row       = row;
    assign o_col       = col;
    assign o_win       = win;

endmodule

`default_nettype wire

/* rtl/cnn_weight_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_weight_store (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic                  i_we,
    input  wire cnn_pkg::chan_t        i_chan,
    input  wire cnn_pkg::coord_t       i_row,
    input  wire cnn_pkg::coord_t       i_col,
    input  wire cnn_pkg::pixel_t       i_weight,
    output cnn_pkg::weight_bank_t      o_weights
);

    cnn_pkg::weight_bank_t bank;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            for (int c = 0; c < `CNN_CHANNELS; c++)
                for (int r = 0; r < `CNN_KSIZE; r++)
                    for (int k = 0; k < `CNN_KSIZE; k++)
                        bank[c][r][k] <= '0;
        end
        else if (i_we)
            bank[i_chan][i_row][i_col] <= i_weight;
    end

    assign o_weights = bank;

endmodule

`default_nettype wire

/* rtl/cnn_tile_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_tile_buffer (
    input  wire logic             i_clk,
    input  wire logic             i_rst,
    input  wire logic             i_we,
    input  wire cnn_pkg::chan_t   i_chan,
    input  wire cnn_pkg::coord_t  i_row,
    input  wire cnn_pkg::coord_t  i_pair,
    input  wire logic [15:0]      i_pixels,
    output cnn_pkg::tile_t        o_tile
);

    cnn_pkg::tile_t  tile;
    cnn_pkg::coord_t col_lo;
    cnn_pkg::coord_t col_hi;

    // only pairs 0 and 1 exist on a 4-wide tile
    assign col_lo = {i_pair[0], 1'b0};
    assign col_hi = {i_pair[0], 1'b1};

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            for (int c = 0; c < `CNN_CHANNELS; c++)
                for (int r = 0; r < `CNN_TSIZE; r++)
                    for (int k = 0; k < `CNN_TSIZE; k++)
                        tile[c][r][k] <= '0;
        end
        else if (i_we)
        begin
            tile[i_chan][i_row][col_lo] <= i_pixels[7:0];
            tile[i_chan][i_row][col_hi] <= i_pixels[15:8];
        end
    end

    assign o_tile = tile;

endmodule

`default_nettype wire

/* rtl/cnn_window_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_window_mac (
    input  wire cnn_pkg::weight_bank_t i_weights,
    input  wire cnn_pkg::tile_t        i_tile,
    input  wire cnn_pkg::win_t         i_win,
    output cnn_pkg::acc_t              o_sum
);

    localparam int NPROD = `CNN_CHANNELS * `CNN_KSIZE * `CNN_KSIZE;

    logic          row_off;
    logic          col_off;
    cnn_pkg::acc_t prod [NPROD];
    cnn_pkg::acc_t sum;

    assign row_off = i_win[1];
    assign col_off = i_win[0];

    // one signed product per channel and kernel tap, sign extended to acc width
    always_comb
    begin
        for (int c = 0; c < `CNN_CHANNELS; c++)
            for (int r = 0; r < `CNN_KSIZE; r++)
                for (int k = 0; k < `CNN_KSIZE; k++)
                    prod[(c * `CNN_KSIZE + r) * `CNN_KSIZE + k] =
                        cnn_pkg::acc_t'(i_tile[c][r + row_off][k + col_off])
                        * cnn_pkg::acc_t'(i_weights[c][r][k]);
    end

    always_comb
    begin
        sum = '0;
        for (int p = 0; p < NPROD; p++)
            sum = sum + prod[p];    // 36 taps fit in 21 bits
    end

    assign o_sum = sum;

endmodule

`default_nettype wire

/* rtl/cnn_relu_pool.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_relu_pool (
    input  wire logic          i_clk,
    input  wire logic          i_rst,
    input  wire logic          i_win_valid,
    input  wire logic          i_win_last,
    input  wire cnn_pkg::acc_t i_sum,
    output logic [7:0]         o_data,
    output logic               o_valid
);

    cnn_pkg::acc_t scaled;
    logic [7:0]    clamped;
    logic [7:0]    run_max;
    logic [7:0]    pooled;

    assign scaled = i_sum >>> `CNN_SHIFT;   // arithmetic, keeps sign

    always_comb
    begin
        if (scaled < 0)
            clamped = 8'd0;                 // relu
        else if (scaled > 127)
            clamped = 8'd127;
        else
            clamped = {1'b0, scaled[6:0]};
    end

    assign pooled = (clamped > run_max) ? clamped : run_max;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            run_max <= '0;
            o_data  <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= 1'b0;
            if (i_win_valid)
            begin
                if (i_win_last)
                begin
                    o_data  <= pooled;
                    o_valid <= 1'b1;
                    run_max <= '0;          // ready for next tile
                end
                else
                    run_max <= pooled;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cnn_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_core (
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic        i_valid,
    input  wire logic [15:0] i_data,
    output logic [7:0]       o_data,
    output logic             o_valid
);

    logic                  kernel_we;
    logic                  image_we;
    logic                  win_valid;
    logic                  win_last;
    cnn_pkg::chan_t        chan;
    cnn_pkg::coord_t       row;
    cnn_pkg::coord_t       col;
    cnn_pkg::win_t         win;
    cnn_pkg::weight_bank_t weights;
    cnn_pkg::tile_t        tile;
    cnn_pkg::acc_t         win_sum;

    cnn_tile_sequencer i_sequencer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .o_kernel_we (kernel_we),
        .o_image_we  (image_we),
        .o_win_valid (win_valid),
        .o_win_last  (win_last),
        .o_chan      (chan),
        .o_row       (row),
        .o_col       (col),
        .o_win       (win)
    );

    cnn_weight_store i_weight_store (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (kernel_we),
        .i_chan    (chan),
        .i_row     (row),
        .i_col     (col),
        .i_weight  (i_data[7:0]),   // upper byte unused for kernels
        .o_weights (weights)
    );

    cnn_tile_buffer i_tile_buffer (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (image_we),
        .i_chan   (chan),
        .i_row    (row),
        .i_pair   (col),
        .i_pixels (i_data),
        .o_tile   (tile)
    );

    cnn_window_mac i_window_mac (
        .i_weights (weights),
        .i_tile    (tile),
        .i_win     (win),
        .o_sum     (win_sum)
    );

    cnn_relu_pool i_relu_pool (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_win_valid (win_valid),
        .i_win_last  (win_last),
        .i_sum       (win_sum),
        .o_data      (o_data),
        .o_valid     (o_valid)
    );

endmodule

`default_nettype wire

/* tb/cnn_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_core_asserts (
    input wire logic       i_clk,
    input wire logic       i_rst,
    input wire logic       i_valid,
    input wire logic [7:0] o_data,
    input wire logic       o_valid
);

    localparam int TILE_BEATS = 17 * `CNN_CHANNELS;  // 9 kernel + 8 image beats per channel

    int   beats;
    logic bad_reset = 1'b0;
    logic bad_idle  = 1'b0;
    logic bad_pulse = 1'b0;
    logic bad_range = 1'b0;
    logic bad_x     = 1'b0;
    logic failed;

    assign failed = bad_reset | bad_idle | bad_pulse | bad_range | bad_x;

    // stops at one tile, so compute cycles never get counted
    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
            beats <= 0;
        else if (i_valid && beats < TILE_BEATS)
            beats <= beats + 1;
    end

    a_reset_values: assert property (@(posedge i_clk) !i_rst |-> !o_valid && o_data == '0)
    else
    begin
        $error("outputs are not cleared while reset is held");
        bad_reset = 1'b1;
    end

    a_idle_before_tile: assert property (@(posedge i_clk) disable iff (!i_rst)
        beats < TILE_BEATS |-> !o_valid && o_data == '0)
    else
    begin
        $error("outputs moved before the first tile was loaded");
        bad_idle = 1'b1;
    end

    a_single_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_valid |=> !o_valid)
    else
    begin
        $error("o_valid stayed high for more than one cycle");
        bad_pulse = 1'b1;
    end

    a_data_range: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_valid |-> o_data <= 8'd127)
    else
    begin
        $error("o_data is above the saturation limit");
        bad_range = 1'b1;
    end

    a_known: assert property (@(posedge i_clk) disable iff (!i_rst)
        !$isunknown({o_valid, o_data}))
    else
    begin
        $error("output ports carry unknown bits");
        bad_x = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/cnn_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_core_tb;

    localparam int TIMEOUT_CYCLES = 2000;   // 8 tiles of at most 150 cycles, plus margin
    localparam int CH = `CNN_CHANNELS;

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic        i_valid;
    logic [15:0] i_data;
    logic [7:0]  o_data;
    logic        o_valid;

    int         weight_m [CH][`CNN_KSIZE][`CNN_KSIZE];
    int         pixel_m [CH][`CNN_TSIZE][`CNN_TSIZE];
    logic [7:0] byte_q [$];
    int         beat_q [$];
    logic [7:0] exp_byte = '0;
    int         exp_beat = 0;
    logic       have_exp = 1'b0;
    int         cycle_count = 0;

    cnn_core i_cnn_core (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_data  (i_data),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

    bind cnn_core cnn_core_asserts i_protocol_asserts (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

    always #20 i_clk = ~i_clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input int got, input int expected);
        stop_with_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($urandom_range(hi - lo, 0));
    endfunction

    task automatic fill_model(input int w_lo, input int w_hi, input int p_lo, input int p_hi);
        for (int c = 0; c < CH; c++)
        begin
            for (int r = 0; r < `CNN_KSIZE; r++)
                for (int k = 0; k < `CNN_KSIZE; k++)
                    weight_m[c][r][k] = rand_between(w_lo, w_hi);
            for (int r = 0; r < `CNN_TSIZE; r++)
                for (int k = 0; k < `CNN_TSIZE; k++)
                    pixel_m[c][r][k] = rand_between(p_lo, p_hi);
        end
    endtask

    // relu, shift and clamp each of the four windows, keep the largest
    function automatic logic [7:0] pooled_byte();
        int best;
        int sum;
        int scaled;
        best = 0;
        for (int dr = 0; dr < 2; dr++)
            for (int dc = 0; dc < 2; dc++)
            begin
                sum = 0;
                for (int c = 0; c < CH; c++)
                    for (int r = 0; r < `CNN_KSIZE; r++)
                        for (int k = 0; k < `CNN_KSIZE; k++)
                            sum += pixel_m[c][dr + r][dc + k] * weight_m[c][r][k];
                scaled = sum >>> `CNN_SHIFT;
                if (scaled < 0)
                    scaled = 0;
                else if (scaled > 127)
                    scaled = 127;
                if (scaled > best)
                    best = scaled;
            end
        return 8'(best);
    endfunction

    task automatic drive_beat(input logic [15:0] data);
        while ($urandom_range(3, 0) == 0)
        begin
            i_valid <= 1'b0;            // idle cycle inside a load phase
            i_data  <= 16'($urandom);
            @(posedge i_clk);
        end
        i_valid <= 1'b1;
        i_data  <= data;
        @(posedge i_clk);
    endtask

    task automatic send_tile();
        for (int c = 0; c < CH; c++)
            for (int r = 0; r < `CNN_KSIZE; r++)
                for (int k = 0; k < `CNN_KSIZE; k++)
                    drive_beat({8'($urandom), 8'(weight_m[c][r][k])});   // upper byte is noise
        for (int c = 0; c < CH; c++)
            for (int r = 0; r < `CNN_TSIZE; r++)
                for (int p = 0; p < `CNN_TSIZE / 2; p++)
                    drive_beat({8'(pixel_m[c][r][2 * p + 1]), 8'(pixel_m[c][r][2 * p])});
        byte_q.push_back(pooled_byte());
        beat_q.push_back(cycle_count);
        repeat (4)
        begin
            i_valid <= 1'b1;            // dropped by the DUT while computing
            i_data  <= 16'($urandom);
            @(posedge i_clk);
        end
    endtask

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_with_failure("timeout: the DUT did not deliver all tiles in time");
        else if (i_cnn_core.i_protocol_asserts.failed)
            stop_with_failure("a protocol assertion on the DUT ports failed");
        else if (o_valid)
            have_exp <= 1'b0;
        else if (!have_exp && byte_q.size() != 0)
        begin
            exp_byte <= byte_q.pop_front();
            exp_beat <= beat_q.pop_front();
            have_exp <= 1'b1;
        end
    end

    a_expected: assert property (@(posedge i_clk) disable iff (!i_rst) o_valid |-> have_exp)
    else
        stop_with_failure("o_valid pulsed with no tile outstanding");

    a_data: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_valid |-> o_data == exp_byte)
    else
        report_mismatch("o_data", $sampled(o_data), $sampled(exp_byte));

    // registered on the 4th edge after the last image beat, seen here on the 5th
    a_latency: assert property (@(posedge i_clk) disable iff (!i_rst)
        o_valid |-> cycle_count - exp_beat == 5)
    else
        report_mismatch("o_valid latency", $sampled(cycle_count - exp_beat) - 1, 4);

    initial
    begin
        void'($urandom(32'h96fe));
        i_rst   <= 1'b0;
        i_valid <= 1'b0;
        i_data  <= '0;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b1;

        fill_model(-128, 127, -128, 127);
        send_tile();
        fill_model(-3, 3, -20, 40);         // mid range sums
        send_tile();
        fill_model(-128, -1, 1, 127);       // all windows negative
        send_tile();
        fill_model(100, 127, 100, 127);     // saturates
        send_tile();
        repeat (4)
        begin
            fill_model(-4, 4, -30, 60);
            send_tile();
        end
        i_valid <= 1'b0;

        while (have_exp || byte_q.size() != 0)
            @(posedge i_clk);
        @(posedge i_clk);
        if (i_cnn_core.i_protocol_asserts.failed)
            stop_with_failure("a protocol assertion on the DUT ports failed");
        else
        begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* cnn_core.f */
+incdir+rtl
rtl/cnn_pkg.sv
rtl/cnn_tile_sequencer.sv
rtl/cnn_weight_store.sv
rtl/cnn_tile_buffer.sv
rtl/cnn_window_mac.sv
rtl/cnn_relu_pool.sv
rtl/cnn_core.sv
tb/cnn_core_asserts.sv
tb/cnn_core_tb.sv
